// File: hdl/instrSlot.sv
// instruction slot that receives one word over four-phase req/ack and holds it for the sequencer
`timescale 1ns/1ps
`default_nettype none

module instrSlot (
	input logic clk,
	input logic reset,
	input logic inReq,
	output logic inAck,
	input isaPkg::instrWord inInstr,
	output logic slotReq,
	input logic slotAck,
	output isaPkg::instrWord slotInstr
);
	import isaPkg::*;

	instrWord holdReg; // captured word
	logic full; // slot occupied
	logic taken; // sequencer acked and its ack has not fallen yet
	logic capture;

	assign capture = inReq && !inAck && !full; // accepting edge

	// input side completes on its own once the word is held
	always_ff @(posedge clk) begin
		if (reset) begin
			inAck <= 1'b0;
		end else if (capture) begin
			inAck <= 1'b1;
		end else if (inAck && !inReq) begin
			inAck <= 1'b0; // source released
		end
	end

	// occupancy and output handshake
	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
			taken <= 1'b0;
			slotReq <= 1'b0;
		end else begin
			if (capture) begin
				full <= 1'b1;
			end
			if (full && !taken && !slotReq && !slotAck) begin
				slotReq <= 1'b1; // offer the word
			end else if (slotReq && slotAck) begin
				slotReq <= 1'b0;
				taken <= 1'b1;
			end else if (taken && !slotAck) begin
				taken <= 1'b0;
				full <= 1'b0; // free for the next word
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			holdReg <= inInstr;
		end
	end

	assign slotInstr = holdReg;

endmodule

`default_nettype wire

// File: hdl/isaPkg.sv
// isa package with the instruction word type, field positions, opcodes and class decoding
`default_nettype none

package isaPkg;

	typedef logic [31:0] instrWord; // one ARM-style instruction

	typedef enum logic [1:0] {
		plainInstr, // anything handled in a single micro-op
		rsrInstr, // data processing with register-shifted register operand
		mulInstr // MUL or MLA
	} instrClass;

	// field positions inside instrWord
	localparam int condHi = 31;
	localparam int condLo = 28;
	localparam int opHi = 24;
	localparam int opLo = 21;
	localparam int accBit = 21; // A bit of the multiply form
	localparam int sBit = 20; // update flags
	localparam int rnHi = 19;
	localparam int rnLo = 16;
	localparam int rdHi = 15;
	localparam int rdLo = 12;
	localparam int operandHi = 11;
	localparam int operandLo = 0;

	localparam logic [3:0] opMov = 4'b1101;
	localparam logic [3:0] opAdd = 4'b0100;
	localparam logic [3:0] rzCode = 4'b0000; // hidden temp register steered by control bits

	// sort a word by bits 27:25, 7 and 4
	function automatic instrClass classifyInstr(input instrWord w);
		instrClass c;
		c = plainInstr;
		if (w[27:25] == 3'b000 && w[4]) begin
			if (w[7])
				c = mulInstr; // multiply space
			else
				c = rsrInstr; // shift amount from a register
		end
		return c;
	endfunction

	// accumulate flag of a multiply, meaningful only for mulInstr
	function automatic logic hasAccumulate(input instrWord w);
		return w[accBit];
	endfunction

endpackage

`default_nettype wire

// File: hdl/uopExpand.sv
// micro-op expander top joining slot, sequencer and issue stage between two four-phase links
`timescale 1ns/1ps
`default_nettype none

module uopExpand (
	input logic clk,
	input logic reset,
	// instruction input link
	input logic inReq,
	output logic inAck,
	input isaPkg::instrWord inInstr,
	// micro-op output link
	output logic outReq,
	input logic outAck,
	output isaPkg::instrWord outInstr,
	output uopPkg::uopCtrl outCtrl
);

	logic slotReq;
	logic slotAck;
	isaPkg::instrWord slotInstr;

	uopLink seqLink (); // sequencer to issue stage

	instrSlot slot (
		.clk (clk),
		.reset (reset),
		.inReq (inReq),
		.inAck (inAck),
		.inInstr (inInstr),
		.slotReq (slotReq),
		.slotAck (slotAck),
		.slotInstr (slotInstr)
	);

	uopSequencer sequencer (
		.clk (clk),
		.reset (reset),
		.slotReq (slotReq),
		.slotAck (slotAck),
		.slotInstr (slotInstr),
		.uopOut (seqLink.sender)
	);

	uopIssue issue (
		.clk (clk),
		.reset (reset),
		.uopIn (seqLink.receiver),
		.outReq (outReq),
		.outAck (outAck),
		.outInstr (outInstr),
		.outCtrl (outCtrl)
	);

endmodule

`default_nettype wire

// File: hdl/uopIssue.sv
// issue stage with the output register and four-phase sender for micro-ops at the top level
`timescale 1ns/1ps
`default_nettype none

module uopIssue (
	input logic clk,
	input logic reset,
	uopLink.receiver uopIn,
	output logic outReq,
	input logic outAck,
	output isaPkg::instrWord outInstr,
	output uopPkg::uopCtrl outCtrl
);
	import uopPkg::*;

	uopRecord holdReg; // micro-op being issued
	logic full;
	logic sent; // sink acked and outAck has not fallen yet
	logic ackReg;
	logic capture;

	// take from the link only into a free register
	assign capture = uopIn.req && !ackReg && !full;

	always_ff @(posedge clk) begin
		if (reset) begin
			ackReg <= 1'b0;
		end else if (capture) begin
			ackReg <= 1'b1;
		end else if (ackReg && !uopIn.req) begin
			ackReg <= 1'b0; // sequencer released
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
			sent <= 1'b0;
			outReq <= 1'b0;
		end else begin
			if (capture) begin
				full <= 1'b1;
			end
			if (full && !sent && !outReq && !outAck) begin
				outReq <= 1'b1; // micro-op on the ports
			end else if (outReq && outAck) begin
				outReq <= 1'b0;
				sent <= 1'b1;
			end else if (sent && !outAck) begin
				sent <= 1'b0;
				full <= 1'b0; // register free again
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			holdReg <= uopIn.uop;
		end
	end

	assign uopIn.ack = ackReg;
	assign outInstr = holdReg.instr;
	assign outCtrl = holdReg.ctrl;

endmodule

`default_nettype wire

// File: hdl/uopLink.sv
// micro-op link carrying one record between stages over a four-phase req/ack handshake
`timescale 1ns/1ps
`default_nettype none

interface uopLink;

	logic req; // sender has a stable uop
	logic ack; // receiver took it
	uopPkg::uopRecord uop;

	modport sender (
		output req,
		output uop,
		input ack
	);

	modport receiver (
		input req,
		input uop,
		output ack
	);

endinterface

`default_nettype wire

// File: hdl/uopPkg.sv
// micro-op package holding the control bits and the record pairing them with an instruction
`default_nettype none

package uopPkg;

	typedef struct packed {
		logic rzWrite; // destination is Rz
		logic rzReadN; // first operand reads Rz
		logic rzReadM; // second operand reads Rz
		logic keepFlags; // suppress flag update
		logic keepV; // V survives even if flags update
		logic lastUop; // closes the instruction
	} uopCtrl;

	typedef struct packed {
		isaPkg::instrWord instr;
		uopCtrl ctrl;
	} uopRecord; // 38 bits

	// control patterns the sequencer emits
	localparam uopCtrl ctrlPass = '{rzWrite: 1'b0, rzReadN: 1'b0, rzReadM: 1'b0,
		keepFlags: 1'b0, keepV: 1'b0, lastUop: 1'b1};
	localparam uopCtrl ctrlRsrFirst = '{rzWrite: 1'b1, rzReadN: 1'b0, rzReadM: 1'b0,
		keepFlags: 1'b1, keepV: 1'b0, lastUop: 1'b0};
	localparam uopCtrl ctrlMulFirst = '{rzWrite: 1'b1, rzReadN: 1'b0, rzReadM: 1'b0,
		keepFlags: 1'b1, keepV: 1'b1, lastUop: 1'b0};
	localparam uopCtrl ctrlSecond = '{rzWrite: 1'b0, rzReadN: 1'b0, rzReadM: 1'b1,
		keepFlags: 1'b0, keepV: 1'b0, lastUop: 1'b1};

endpackage

`default_nettype wire

// File: hdl/uopSequencer.sv
// micro-op sequencer that classifies a held word and emits its one or two micro-ops in order
`timescale 1ns/1ps
`default_nettype none

module uopSequencer (
	input logic clk,
	input logic reset,
	input logic slotReq,
	output logic slotAck,
	input isaPkg::instrWord slotInstr,
	uopLink.sender uopOut
);
	import isaPkg::*;
	import uopPkg::*;

	typedef enum logic [1:0] {
		idle, // waiting for a word from the slot
		firstUop, // build first (or only) micro-op
		secondUop, // build the follow-up micro-op
		waitAck // link handshake in progress
	} seqState;

	seqState state;
	instrWord curInstr; // word being expanded
	instrClass curClass;
	logic isMla;
	logic twoUops; // instruction needs the Rz split
	logic onLast; // uop on the link closes the instruction
	logic reqReg;
	logic takeWord;
	uopRecord uopReg; // record presented on the link
	uopRecord firstRec;
	uopRecord secondRec;

	assign curClass = classifyInstr(curInstr);
	assign isMla = (curClass == mulInstr) && hasAccumulate(curInstr);
	assign twoUops = (curClass == rsrInstr) || isMla; // plain MUL passes through
	assign takeWord = (state == idle) && slotReq && !slotAck;

	// first micro-op or the passthrough copy
	always_comb begin
		firstRec.instr = curInstr;
		firstRec.ctrl = ctrlPass;
		if (curClass == rsrInstr) begin
			// MOV Rz, shifted operand
			firstRec.instr[opHi:opLo] = opMov;
			firstRec.instr[sBit] = 1'b0; // flags come from the real op
			firstRec.instr[rnHi:rnLo] = 4'b0000; // Rn unused by MOV
			firstRec.instr[rdHi:rdLo] = rzCode;
			firstRec.ctrl = ctrlRsrFirst;
		end else if (isMla) begin
			// MUL into Rz with the accumulator dropped
			firstRec.instr[accBit] = 1'b0;
			firstRec.instr[sBit] = 1'b0;
			firstRec.instr[rdHi:rdLo] = 4'b0000; // SBZ in the MUL form
			firstRec.ctrl = ctrlMulFirst;
		end
	end

	// second micro-op reads Rz as operand m
	always_comb begin
		secondRec.ctrl = ctrlSecond;
		if (isMla) begin
			secondRec.instr = '0; // register-form data processing
			secondRec.instr[condHi:condLo] = curInstr[condHi:condLo];
			secondRec.instr[opHi:opLo] = opAdd;
			secondRec.instr[sBit] = curInstr[sBit]; // MLA's own S applies here
			secondRec.instr[rnHi:rnLo] = curInstr[rdHi:rdLo]; // accumulator
			secondRec.instr[rdHi:rdLo] = curInstr[rnHi:rnLo]; // MLA destination
		end else begin
			secondRec.instr = curInstr; // original op keeps Rn and Rd
		end
		secondRec.instr[operandHi:operandLo] = 12'(rzCode); // Rz with no shift
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			slotAck <= 1'b0;
			reqReg <= 1'b0;
			onLast <= 1'b0;
		end else begin
			if (slotAck && !slotReq) begin
				slotAck <= 1'b0; // slot handshake closes
			end
			case (state)
				idle: begin
					if (takeWord) begin
						slotAck <= 1'b1;
						state <= firstUop;
					end
				end
				firstUop: begin
					reqReg <= 1'b1;
					onLast <= !twoUops;
					state <= waitAck;
				end
				secondUop: begin
					reqReg <= 1'b1;
					onLast <= 1'b1;
					state <= waitAck;
				end
				waitAck: begin
					if (reqReg && uopOut.ack) begin
						reqReg <= 1'b0;
					end else if (!reqReg && !uopOut.ack) begin
						state <= onLast ? idle : secondUop; // link back to rest
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (takeWord) begin
			curInstr <= slotInstr;
		end
		if (state == firstUop) begin
			uopReg <= firstRec;
		end else if (state == secondUop) begin
			uopReg <= secondRec;
		end
	end

	assign uopOut.req = reqReg;
	assign uopOut.uop = uopReg;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the micro-op expander testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module uopExpandTb -f vlog.f -o uopExpandSim

./obj_dir/uopExpandSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "All tests passed" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: tb/uopRefModel.svh
// reference model giving the expected micro-ops for one instruction word
`ifndef UOP_REF_MODEL_SVH
`define UOP_REF_MODEL_SVH

// returns the micro-op count with the records in first and second
function automatic int expandRef(
	input instrWord w,
	output uopRecord first,
	output uopRecord second
);
	logic dpSpace; // bits 27:25 clear
	logic shiftByReg; // RSR data processing
	logic multiplyAcc; // MLA
	dpSpace = (w[27:25] == 3'b000);
	shiftByReg = dpSpace && !w[7] && w[4];
	multiplyAcc = dpSpace && w[7] && w[4] && w[21];
	first.instr = w; // passthrough unless split
	first.ctrl = '0;
	first.ctrl.lastUop = 1'b1;
	second = '0;
	if (shiftByReg) begin
		// MOV Rz, Rm shifted by Rs leaves the flags alone
		first.instr = {w[31:25], 4'b1101, 1'b0, 8'h00, w[11:0]};
		first.ctrl = '0;
		first.ctrl.rzWrite = 1'b1;
		first.ctrl.keepFlags = 1'b1;
		// original op with Rz as plain operand m
		second.instr = {w[31:12], 12'h000};
		second.ctrl.rzReadM = 1'b1;
		second.ctrl.lastUop = 1'b1;
		return 2;
	end
	if (multiplyAcc) begin
		// MUL Rz, Rm, Rs with A and S cleared and the Rn field zero
		first.instr = {w[31:22], 2'b00, w[19:16], 4'h0, w[11:0]};
		first.ctrl = '0;
		first.ctrl.rzWrite = 1'b1;
		first.ctrl.keepFlags = 1'b1;
		first.ctrl.keepV = 1'b1; // MLA leaves V alone
		// ADD Rd, Rn, Rz carrying the MLA's S bit
		second.instr = {w[31:28], 3'b000, 4'b0100, w[20], w[15:12], w[19:16], 12'h000};
		second.ctrl.rzReadM = 1'b1;
		second.ctrl.lastUop = 1'b1;
		return 2;
	end
	return 1;
endfunction

`endif

// File: tb/uopExpandTb.sv
// testbench for the micro-op expander that drives both four-phase links and scores every micro-op
`timescale 1ns/1ps
`default_nettype none

module uopExpandTb;
	import isaPkg::*;
	import uopPkg::*;

	`include "uopRefModel.svh"

	localparam int numDirected = 10;
	localparam int numRandom = 40;
	localparam int cycleLimit = 40 * (numDirected + numRandom); // per-word budget

	localparam instrWord directedWords [numDirected] = '{
		32'hE0821003, // ADD r1, r2, r3
		32'hE3A01005, // MOV r1, #5
		32'hE5912000, // LDR r2, [r1]
		32'hE0000291, // MUL r0, r1, r2
		32'hE0100291, // MULS r0, r1, r2
		32'hE0810312, // ADD r0, r1, r2, LSL r3
		32'hE0554756, // SUBS r4, r5, r6, ASR r7
		32'h41A0C170, // MOVMI r12, r0, ROR r1
		32'hE0203291, // MLA r0, r1, r2, r3
		32'h10354697 // MLASNE r5, r7, r6, r4
	};

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic inReq = 1'b0;
	logic inAck;
	instrWord inInstr = '0;
	logic outReq;
	logic outAck = 1'b0;
	instrWord outInstr;
	uopCtrl outCtrl;

	uopRecord expQ[$]; // scoreboard with the oldest first
	int valueErrors = 0;
	int protocolErrors = 0;
	int wordsSent = 0;
	int uopsSeen = 0;
	int cycleCount = 0;
	logic bpEnable = 1'b0; // random outAck delay
	int unsigned seedVal;

	uopExpand u_dut (
		.clk (clk),
		.reset (reset),
		.inReq (inReq),
		.inAck (inAck),
		.inInstr (inInstr),
		.outReq (outReq),
		.outAck (outAck),
		.outInstr (outInstr),
		.outCtrl (outCtrl)
	);

	always #20 clk = ~clk; // 40 ns period

	task automatic checkInstr(input string name, input instrWord expected, input instrWord actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("FAILED at %0t: %s expected %08h got %08h", $time, name, expected, actual);
		end
	endtask

	task automatic checkCtrl(input string name, input uopCtrl expected, input uopCtrl actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("FAILED at %0t: %s expected %06b got %06b", $time, name, expected, actual);
		end
	endtask

	task automatic checkLogic(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("FAILED at %0t: %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	// queue the expected micro-ops, then send the word over the input link
	task automatic sendWord(input instrWord w);
		uopRecord a;
		uopRecord b;
		int n;
		n = expandRef(w, a, b);
		expQ.push_back(a);
		if (n == 2)
			expQ.push_back(b);
		wordsSent++;
		@(posedge clk);
		#1;
		inInstr = w;
		inReq = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!inAck);
		inReq = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (inAck);
	endtask

	// random word biased toward the split classes
	function automatic instrWord randomWord();
		instrWord w;
		int sel;
		w = $urandom;
		sel = $urandom_range(0, 3);
		if (sel != 3)
			w[27:25] = 3'b000;
		case (sel)
			0: {w[7], w[4]} = 2'b01; // RSR
			1: {w[21], w[7], w[4]} = 3'b111; // MLA
			2: {w[21], w[7], w[4]} = 3'b011; // MUL
			default: ; // raw word
		endcase
		return w;
	endfunction

	task automatic waitDrain();
		while (expQ.size() != 0 || outReq)
			@(posedge clk);
	endtask

	// pop the oldest expected record and compare against the ports
	task automatic compareUop();
		uopRecord exp;
		uopsSeen++;
		if (expQ.size() == 0) begin
			protocolErrors++;
			$display("at %0t an extra micro-op %08h appeared with nothing expected", $time, outInstr);
		end else begin
			exp = expQ.pop_front();
			checkInstr("outInstr", exp.instr, outInstr);
			checkCtrl("outCtrl", exp.ctrl, outCtrl);
		end
	endtask

	// sink answers outReq and checks each micro-op as it is offered
	initial begin
		int delay;
		wait (reset == 1'b0);
		forever begin
			@(posedge clk);
			#1;
			if (outReq && !outAck) begin
				compareUop();
				if (bpEnable) begin
					delay = $urandom_range(0, 3);
					repeat (delay) @(posedge clk);
					if (delay != 0)
						#1;
				end
				outAck = 1'b1;
				do begin
					@(posedge clk);
					#1;
				end while (outReq);
				outAck = 1'b0;
			end
		end
	end

	// watchdog catches a missing micro-op
	initial begin
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d cycles, %0d micro-ops never arrived", cycleCount, expQ.size());
		$display("Some tests failed");
		$finish;
	end

	initial begin
		seedVal = $urandom(32'h6eeb16cf);
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (5) begin // idle after reset
			@(posedge clk);
			#1;
			checkLogic("inAck", 1'b0, inAck);
			checkLogic("outReq", 1'b0, outReq);
		end
		for (int i = 0; i < numDirected; i++) begin
			sendWord(directedWords[i]);
			waitDrain();
		end
		bpEnable = 1'b1;
		for (int i = 0; i < numRandom; i++)
			sendWord(randomWord()); // back to back under back-pressure
		waitDrain();
		repeat (10) @(posedge clk); // catch any trailing extras
		$display("summary: %0d words, %0d micro-ops, %0d value errors, %0d protocol errors",
			wordsSent, uopsSeen, valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tb
hdl/isaPkg.sv
hdl/uopPkg.sv
hdl/uopLink.sv
hdl/instrSlot.sv
hdl/uopSequencer.sv
hdl/uopIssue.sv
hdl/uopExpand.sv
tb/uopExpandTb.sv
